// File: Makefile
# Verilator build and run of the PCIe configuration register bank testbench

VERILATOR ?= verilator
TOP       ?= pcie_cfg_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= TEST RESULT: FAIL

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+.
pcie_cfg_pkg.sv
pcie_cfg_regfile.sv
pcie_cfg_mgmt_seq.sv
pcie_cfg_status_clear.sv
pcie_cfg_top.sv
pcie_cfg_assert.sv
pcie_cfg_tb.sv

// File: pcie_cfg_assert.sv
// Concurrent assertions on the top-level ports bound into the top level
`timescale 1ns/1ns

module pcie_cfg_assert import pcie_cfg_pkg::*;
(
    input logic    clk_pcie,
    input logic    rst,
    input logic    i_cmd_valid,
    input cmd_op_e i_cmd_op,
    input logic    o_cmd_ready,
    input logic    o_rsp_valid,
    input logic    o_cfg_mgmt_rd_en,
    input logic    o_cfg_mgmt_wr_en
);

    int fail_count = 0;

    // One configuration access at a time
    assert property (@(posedge clk_pcie) disable iff (rst)
                     !(o_cfg_mgmt_rd_en && o_cfg_mgmt_wr_en))
    else
    begin
        fail_count = fail_count + 1;
        $error("Management read and write enables high together");
    end

    assert property (@(posedge clk_pcie) disable iff (rst)
                     o_rsp_valid |-> $past(i_cmd_valid && o_cmd_ready &&
                                           (i_cmd_op == CMD_READ)))
    else
    begin
        fail_count = fail_count + 1;
        $error("Read response without an accepted read");
    end

    assert property (@(posedge clk_pcie) $fell(rst) |-> o_cmd_ready)   // Ready out of reset
    else
    begin
        fail_count = fail_count + 1;
        $error("Command port not ready after reset");
    end

endmodule

bind pcie_cfg_top pcie_cfg_assert u_pcie_cfg_assert (
    .clk_pcie         (clk_pcie),
    .rst              (rst),
    .i_cmd_valid      (i_cmd_valid),
    .i_cmd_op         (i_cmd_op),
    .o_cmd_ready      (o_cmd_ready),
    .o_rsp_valid      (o_rsp_valid),
    .o_cfg_mgmt_rd_en (o_cfg_mgmt_rd_en),
    .o_cfg_mgmt_wr_en (o_cfg_mgmt_wr_en)
);

// File: pcie_cfg_defines.svh
// Window sizes, bit positions, magic values and reset defaults
// of the PCIe configuration register bank
`ifndef PCIE_CFG_DEFINES_SVH
`define PCIE_CFG_DEFINES_SVH

// -------------------------------------------------------------------
// Window sizes and identification
// -------------------------------------------------------------------
`define CFG_RO_BITS              224
`define CFG_RW_BITS              224
`define CFG_RO_MAGIC             16'h2301
`define CFG_RW_MAGIC             16'h6745

// Reset defaults
`define CFG_DSN_DEFAULT          64'h0123_4567_89AB_CDEF
`define CFG_CLEAR_TIMER_DEFAULT  32'd62500     // 1 ms at 62.5 MHz

// -------------------------------------------------------------------
// Read-write window bit positions
// -------------------------------------------------------------------
`define CFG_RWPOS_RD_EN          16    // Start a management read
`define CFG_RWPOS_WR_EN          17    // Start a management write
`define CFG_RWPOS_WAIT_COMPLETE  18    // Hold commands while busy
`define CFG_RWPOS_STATUS_CL_EN   19
`define CFG_RWPOS_COMMAND_EN     20

`define CFG_RWPOS_DSN            64    // +008
`define CFG_RWPOS_MGMT_DI        128   // +010
`define CFG_RWPOS_MGMT_DWADDR    160   // +014 dword address
`define CFG_RWPOS_MGMT_RDONLY    170
`define CFG_RWPOS_MGMT_RW1C      171
`define CFG_RWPOS_MGMT_BYTE_EN   172
`define CFG_RWPOS_CLEAR_TIMER    192   // +018

// Status-clear write to the command/status dword
`define CFG_CLEAR_DI             32'hFF00_0007
`define CFG_CLEAR_DWADDR         10'd1

`endif

// File: pcie_cfg_mgmt_seq.sv
// Configuration management sequencer with result capture
`timescale 1ns/1ns

module pcie_cfg_mgmt_seq import pcie_cfg_pkg::*;
(
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_rd_pend,
    input  logic        i_wr_pend,
    input  logic        i_cfg_mgmt_rd_wr_done,
    input  logic [31:0] i_cfg_mgmt_do,
    input  logic [9:0]  i_cfg_mgmt_dwaddr,
    input  logic [3:0]  i_cfg_mgmt_byte_en,
    output logic        o_rd_taken,
    output logic        o_wr_taken,
    output logic        o_busy,
    output logic        o_cfg_mgmt_rd_en,
    output logic        o_cfg_mgmt_wr_en,
    output logic        o_res_valid,
    output logic [9:0]  o_res_addr,
    output logic [31:0] o_res_data,
    output logic [3:0]  o_res_byte_en
);

    mgmt_state_e state;
    logic        done;

    // Read wins over write
    assign o_rd_taken       = (state == MGMT_IDLE) & i_rd_pend;
    assign o_wr_taken       = (state == MGMT_IDLE) & i_wr_pend & ~i_rd_pend;
    assign o_busy           = (state != MGMT_IDLE);
    assign done             = o_busy & i_cfg_mgmt_rd_wr_done;
    assign o_cfg_mgmt_rd_en = (state == MGMT_READ) & ~i_cfg_mgmt_rd_wr_done;
    assign o_cfg_mgmt_wr_en = (state == MGMT_WRITE) & ~i_cfg_mgmt_rd_wr_done;

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            state       <= MGMT_IDLE;
            o_res_valid <= 1'b0;
        end
        else
        begin
            case (state)
                MGMT_IDLE:
                begin
                    if (o_rd_taken)
                        state <= MGMT_READ;
                    else if (o_wr_taken)
                        state <= MGMT_WRITE;
                end
                MGMT_READ, MGMT_WRITE:
                begin
                    if (done)
                        state <= MGMT_IDLE;
                end
                default: state <= MGMT_IDLE;
            endcase

            if (o_rd_taken | o_wr_taken)
                o_res_valid <= 1'b0;   // Stale result
            else if (done)
                o_res_valid <= 1'b1;
        end
    end

    // Completed operation
    always_ff @(posedge clk_pcie)
    begin
        if (done)
        begin
            o_res_addr    <= i_cfg_mgmt_dwaddr;
            o_res_data    <= i_cfg_mgmt_do;
            o_res_byte_en <= i_cfg_mgmt_byte_en;
        end
    end

endmodule

// File: pcie_cfg_pkg.sv
// Shared types of the PCIe configuration register bank
package pcie_cfg_pkg;

    // Management sequencer states
    typedef enum logic [1:0] {
        MGMT_IDLE  = 2'd0,
        MGMT_READ  = 2'd1,
        MGMT_WRITE = 2'd2
    } mgmt_state_e;

    // Command port opcodes
    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } cmd_op_e;

    // Byte address with the read-write window select in bit 15
    typedef logic [15:0] cfg_addr_t;

endpackage

// File: pcie_cfg_regfile.sv
// Read-write and read-only register windows with command decode,
// read response and management request bits
`timescale 1ns/1ns
`include "pcie_cfg_defines.svh"

module pcie_cfg_regfile import pcie_cfg_pkg::*;
(
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_cmd_valid,
    input  cmd_op_e     i_cmd_op,
    input  cfg_addr_t   i_cmd_addr,
    input  logic [15:0] i_cmd_mask,
    input  logic [15:0] i_cmd_value,
    input  logic        i_rd_taken,
    input  logic        i_wr_taken,
    input  logic        i_mgmt_busy,
    input  logic        i_clear_fire,
    input  logic [7:0]  i_cfg_bus_number,
    input  logic [4:0]  i_cfg_device_number,
    input  logic [2:0]  i_cfg_function_number,
    input  logic [15:0] i_cfg_command,
    input  logic [15:0] i_cfg_status,
    input  logic [31:0] i_cfg_mgmt_do,
    input  logic        i_cfg_mgmt_rd_en,
    input  logic        i_cfg_mgmt_wr_en,
    input  logic        i_res_valid,
    input  logic [9:0]  i_res_addr,
    input  logic [31:0] i_res_data,
    input  logic [3:0]  i_res_byte_en,
    output logic        o_cmd_ready,
    output logic        o_cmd_accept,
    output logic        o_rsp_valid,
    output cfg_addr_t   o_rsp_addr,
    output logic [15:0] o_rsp_data,
    output logic        o_rd_pend,
    output logic        o_wr_pend,
    output logic        o_clear_status_en,
    output logic        o_clear_command_en,
    output logic [31:0] o_clear_limit,
    output logic [63:0] o_cfg_dsn,
    output logic [31:0] o_cfg_mgmt_di,
    output logic [9:0]  o_cfg_mgmt_dwaddr,
    output logic [3:0]  o_cfg_mgmt_byte_en,
    output logic        o_cfg_mgmt_wr_readonly,
    output logic        o_cfg_mgmt_wr_rw1c_as_rw,
    output logic [15:0] o_pcie_id
);

    logic [`CFG_RO_BITS-1:0]  ro;
    logic [`CFG_RW_BITS-1:0]  rw;
    logic [17:0]              cmd_bit;         // Bit address inside a window
    logic                     cmd_write;
    logic [`CFG_RW_BITS+15:0] wr_mask_ext;
    logic [`CFG_RW_BITS+15:0] wr_value_ext;
    logic [`CFG_RW_BITS-1:0]  wr_mask;
    logic [`CFG_RW_BITS+15:0] rd_shift;

    // -------------------------------------------------------------------
    // Read-only window
    // -------------------------------------------------------------------
    assign ro[15:0]    = `CFG_RO_MAGIC;        // +000
    assign ro[16]      = i_cfg_mgmt_rd_en;     // +002 live enables
    assign ro[17]      = i_cfg_mgmt_wr_en;
    assign ro[31:18]   = '0;
    assign ro[63:32]   = `CFG_RO_BITS / 8;     // +004 byte count
    assign ro[71:64]   = i_cfg_bus_number;     // +008 PCIe id
    assign ro[76:72]   = i_cfg_device_number;
    assign ro[79:77]   = i_cfg_function_number;
    assign ro[95:80]   = i_cfg_command;        // +00A
    assign ro[111:96]  = i_cfg_status;         // +00C
    assign ro[127:112] = '0;
    assign ro[159:128] = i_cfg_mgmt_do;        // +010
    assign ro[169:160] = i_res_addr;           // +014 last result
    assign ro[170]     = 1'b0;
    assign ro[171]     = i_res_valid;
    assign ro[175:172] = i_res_byte_en;
    assign ro[191:176] = '0;
    assign ro[223:192] = i_res_data;           // +018

    // -------------------------------------------------------------------
    // Command decode
    // -------------------------------------------------------------------
    // Stall only while waiting on a pending or running request
    assign o_cmd_ready  = ~(rw[`CFG_RWPOS_WAIT_COMPLETE] &
                            (rw[`CFG_RWPOS_RD_EN] | rw[`CFG_RWPOS_WR_EN] | i_mgmt_busy));
    assign o_cmd_accept = i_cmd_valid & o_cmd_ready;
    assign cmd_write    = o_cmd_accept & (i_cmd_op == CMD_WRITE) & i_cmd_addr[15];
    assign cmd_bit      = {i_cmd_addr[14:0], 3'b000};

    // Bits shifted past the window drop out
    assign wr_mask_ext  = {{`CFG_RW_BITS{1'b0}}, i_cmd_mask} << cmd_bit;
    assign wr_value_ext = {{`CFG_RW_BITS{1'b0}}, i_cmd_value} << cmd_bit;
    assign wr_mask      = wr_mask_ext[`CFG_RW_BITS-1:0];
    assign rd_shift     = {16'h0000, (i_cmd_addr[15] ? rw : ro)} >> cmd_bit;

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            rw                                   <= '0;
            rw[15:0]                             <= `CFG_RW_MAGIC;
            rw[63:32]                            <= `CFG_RW_BITS / 8;
            rw[`CFG_RWPOS_DSN +: 64]             <= `CFG_DSN_DEFAULT;
            rw[`CFG_RWPOS_MGMT_BYTE_EN +: 4]     <= 4'hF;
            rw[`CFG_RWPOS_CLEAR_TIMER +: 32]     <= `CFG_CLEAR_TIMER_DEFAULT;
            o_rsp_valid                          <= 1'b0;
        end
        else
        begin
            o_rsp_valid <= o_cmd_accept & (i_cmd_op == CMD_READ);
            if (cmd_write)
                rw <= (rw & ~wr_mask) | (wr_value_ext[`CFG_RW_BITS-1:0] & wr_mask);

            // Request bits drop once the sequencer has them
            if (i_rd_taken)
                rw[`CFG_RWPOS_RD_EN] <= 1'b0;
            if (i_wr_taken)
                rw[`CFG_RWPOS_WR_EN] <= 1'b0;

            // Timer fire never coincides with an accepted command
            if (i_clear_fire)
            begin
                rw[`CFG_RWPOS_WR_EN]               <= 1'b1;
                rw[`CFG_RWPOS_MGMT_DI +: 32]       <= `CFG_CLEAR_DI;
                rw[`CFG_RWPOS_MGMT_DWADDR +: 10]   <= `CFG_CLEAR_DWADDR;
                rw[`CFG_RWPOS_MGMT_RDONLY]         <= 1'b0;
                rw[`CFG_RWPOS_MGMT_RW1C]           <= 1'b0;
                rw[`CFG_RWPOS_MGMT_BYTE_EN +: 4]   <= {rw[`CFG_RWPOS_STATUS_CL_EN], 1'b0,
                                                       rw[`CFG_RWPOS_COMMAND_EN],
                                                       rw[`CFG_RWPOS_COMMAND_EN]};
            end
        end
    end

    // Read response payload taken before any same-cycle write
    always_ff @(posedge clk_pcie)
    begin
        if (o_cmd_accept && (i_cmd_op == CMD_READ))
        begin
            o_rsp_addr <= i_cmd_addr;
            o_rsp_data <= rd_shift[15:0];
        end
    end

    // -------------------------------------------------------------------
    // Field outputs
    // -------------------------------------------------------------------
    assign o_rd_pend                = rw[`CFG_RWPOS_RD_EN];
    assign o_wr_pend                = rw[`CFG_RWPOS_WR_EN];
    assign o_clear_status_en        = rw[`CFG_RWPOS_STATUS_CL_EN];
    assign o_clear_command_en       = rw[`CFG_RWPOS_COMMAND_EN];
    assign o_clear_limit            = rw[`CFG_RWPOS_CLEAR_TIMER +: 32];
    assign o_cfg_dsn                = rw[`CFG_RWPOS_DSN +: 64];
    assign o_cfg_mgmt_di            = rw[`CFG_RWPOS_MGMT_DI +: 32];
    assign o_cfg_mgmt_dwaddr        = rw[`CFG_RWPOS_MGMT_DWADDR +: 10];
    assign o_cfg_mgmt_byte_en       = rw[`CFG_RWPOS_MGMT_BYTE_EN +: 4];
    assign o_cfg_mgmt_wr_readonly   = rw[`CFG_RWPOS_MGMT_RDONLY];
    assign o_cfg_mgmt_wr_rw1c_as_rw = rw[`CFG_RWPOS_MGMT_RW1C];
    assign o_pcie_id                = ro[79:64];   // Function, device, bus

endmodule

// File: pcie_cfg_status_clear.sv
// Idle-cycle timer for the periodic status-clear write
`timescale 1ns/1ns

module pcie_cfg_status_clear
(
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_status_en,
    input  logic        i_command_en,
    input  logic [31:0] i_limit,
    input  logic        i_cmd_accept,
    input  logic        i_rd_pend,
    input  logic        i_wr_pend,
    input  logic        i_mgmt_busy,
    output logic        o_fire
);

    logic [31:0] count;
    logic        idle;

    // Count only while nothing else touches the management fields
    assign idle   = (i_status_en | i_command_en) & ~i_cmd_accept &
                    ~i_rd_pend & ~i_wr_pend & ~i_mgmt_busy;
    assign o_fire = idle & (count == i_limit);

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            count <= '0;
        else if (o_fire)
            count <= '0;
        else if (idle)
            count <= count + 32'd1;
    end

endmodule

// File: pcie_cfg_tb.sv
// Testbench for the PCIe configuration register bank with data-file stimulus
// and a configuration-space responder model
`timescale 1ns/1ns

module pcie_cfg_tb import pcie_cfg_pkg::*;
();

    localparam int TIMEOUT  = 1000;    // Per-wait limit in cycles or polls
    localparam int MAX_VECS = 64;

    logic        clk_pcie;
    logic        rst;
    logic        i_cmd_valid;
    cmd_op_e     i_cmd_op;
    cfg_addr_t   i_cmd_addr;
    logic [15:0] i_cmd_mask;
    logic [15:0] i_cmd_value;
    logic        o_cmd_ready;
    logic        o_rsp_valid;
    cfg_addr_t   o_rsp_addr;
    logic [15:0] o_rsp_data;
    logic [7:0]  i_cfg_bus_number;
    logic [4:0]  i_cfg_device_number;
    logic [2:0]  i_cfg_function_number;
    logic [15:0] i_cfg_command;
    logic [15:0] i_cfg_status;
    logic [31:0] i_cfg_mgmt_do = 32'd0;
    logic        i_cfg_mgmt_rd_wr_done = 1'b0;
    logic        o_cfg_mgmt_rd_en;
    logic        o_cfg_mgmt_wr_en;
    logic [31:0] o_cfg_mgmt_di;
    logic [9:0]  o_cfg_mgmt_dwaddr;
    logic [3:0]  o_cfg_mgmt_byte_en;
    logic        o_cfg_mgmt_wr_readonly;
    logic        o_cfg_mgmt_wr_rw1c_as_rw;
    logic [63:0] o_cfg_dsn;
    logic [15:0] o_pcie_id;

    // Test vector fields are test id, op, address, mask, value and expected
    logic [71:0] vectors [0:MAX_VECS-1];
    logic [31:0] snap_di;
    logic [9:0]  snap_dwaddr;
    logic [3:0]  snap_byte_en;
    logic        snap_rdonly;
    logic        snap_rw1c;
    logic [31:0] lcg_state = 32'd99676;
    int          resp_cnt = 0;
    int          resp_latency = 2;
    int          errors;
    int          timeouts;
    int          checks;
    int          overlap_errors = 0;
    int          total_errors;

    pcie_cfg_top u_pcie_cfg_top (.*);

    initial clk_pcie = 1'b0;
    always #50 clk_pcie = ~clk_pcie;    // 100 ns period

    // -------------------------------------------------------------------
    // Configuration-space responder
    // -------------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk_pcie)
    begin
        #5;
        if (rst || i_cfg_mgmt_rd_wr_done)
        begin
            i_cfg_mgmt_rd_wr_done = 1'b0;
            resp_cnt              = 0;
        end
        else if (o_cfg_mgmt_rd_en || o_cfg_mgmt_wr_en)
        begin
            if (resp_cnt == 0)
            begin
                lcg_state    = lcg_next(lcg_state);
                resp_latency = 2 + int'(lcg_state[18:16]);   // 2 to 9 cycles
            end
            resp_cnt = resp_cnt + 1;
            if (resp_cnt >= resp_latency)
            begin
                i_cfg_mgmt_do         = 32'hC0DE_0000 + {22'd0, o_cfg_mgmt_dwaddr};
                i_cfg_mgmt_rd_wr_done = 1'b1;
            end
        end
    end

    always @(negedge clk_pcie)
    begin
        if (!rst && o_cfg_mgmt_rd_en && o_cfg_mgmt_wr_en)
        begin
            overlap_errors = overlap_errors + 1;
            $display("Read and write enables are both high at %0t", $time);
        end
    end

    // -------------------------------------------------------------------
    // Helpers enter and leave 5 ns after a rising edge
    // -------------------------------------------------------------------
    function automatic string test_name(input logic [3:0] id);
        string s;
        case (id)
            4'd1:    s = "window_magic";
            4'd2:    s = "masked_write";
            4'd3:    s = "mgmt_read";
            4'd4:    s = "mgmt_write";
            4'd5:    s = "clear_timer";
            4'd6:    s = "wait_complete";
            default: s = "unknown";
        endcase
        return s;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks = checks + 1;
        if (actual !== expected)
        begin
            errors = errors + 1;
            $display("Error: %s expected %h, actual %h", name, expected, actual);
        end
    endtask

    // PCIe id and DSN ports carry the same bits as their window fields
    task automatic check_mirrored_ports(input string name, input cfg_addr_t addr,
                                        input logic [15:0] mask,
                                        input logic [15:0] expected);
        int pos;
        if (addr == 16'h0008)
            check_value({name, " pcie_id"}, expected, o_pcie_id & mask);
        else if (addr >= 16'h8008 && addr <= 16'h800e)
        begin
            pos = 8 * int'(addr[3:0] - 4'd8);
            check_value({name, " dsn"}, expected, o_cfg_dsn[pos +: 16] & mask);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts = timeouts + 1;
        $display("Timeout: %s at %0t", what, $time);
    endtask

    task automatic issue_cmd(input cmd_op_e op, input cfg_addr_t addr,
                             input logic [15:0] mask, input logic [15:0] value);
        int n;
        n           = 0;
        i_cmd_op    = op;
        i_cmd_addr  = addr;
        i_cmd_mask  = mask;
        i_cmd_value = value;
        i_cmd_valid = 1'b1;
        @(negedge clk_pcie);
        while (!o_cmd_ready && n < TIMEOUT)
        begin
            @(negedge clk_pcie);
            n = n + 1;
        end
        if (!o_cmd_ready)
            report_timeout("command was never accepted");
        @(posedge clk_pcie);            // Accept edge
        #5;
        i_cmd_valid = 1'b0;
    endtask

    task automatic read_word(input string name, input cfg_addr_t addr,
                             output logic [15:0] data);
        int n;
        n = 0;
        issue_cmd(CMD_READ, addr, 16'h0000, 16'h0000);
        @(negedge clk_pcie);
        while (!o_rsp_valid && n < TIMEOUT)
        begin
            @(negedge clk_pcie);
            n = n + 1;
        end
        if (!o_rsp_valid)
            report_timeout("no read response");
        check_value({name, " rsp_addr"}, addr, o_rsp_addr);
        data = o_rsp_data;
        @(posedge clk_pcie);
        #5;
    endtask

    task automatic poll_until(input string name, input cfg_addr_t addr,
                              input logic [15:0] mask, input logic [15:0] expected);
        logic [15:0] data;
        int          n;
        n = 0;
        read_word(name, addr, data);
        while (((data & mask) != expected) && n < TIMEOUT)
        begin
            read_word(name, addr, data);
            n = n + 1;
        end
        if (n >= TIMEOUT)
            report_timeout("polled value never matched");
        check_value(name, expected, data & mask);
    endtask

    task automatic capture_write_fields();
        int n;
        n = 0;
        @(negedge clk_pcie);
        while (!o_cfg_mgmt_wr_en && n < TIMEOUT)
        begin
            @(negedge clk_pcie);
            n = n + 1;
        end
        if (!o_cfg_mgmt_wr_en)
            report_timeout("management write enable never rose");
        snap_di      = o_cfg_mgmt_di;
        snap_dwaddr  = o_cfg_mgmt_dwaddr;
        snap_byte_en = o_cfg_mgmt_byte_en;
        snap_rdonly  = o_cfg_mgmt_wr_readonly;
        snap_rw1c    = o_cfg_mgmt_wr_rw1c_as_rw;
        @(posedge clk_pcie);
        #5;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk_pcie);
        while (!o_cmd_ready && n < TIMEOUT)
        begin
            @(negedge clk_pcie);
            n = n + 1;
        end
        if (!o_cmd_ready)
            report_timeout("command ready never returned");
        @(posedge clk_pcie);
        #5;
    endtask

    // -------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------
    initial
    begin : stimulus
        logic [71:0] vec;
        logic [15:0] data;
        string       name;
        int          idx;

        errors                = 0;
        timeouts              = 0;
        checks                = 0;
        rst                   = 1'b1;
        i_cmd_valid           = 1'b0;
        i_cmd_op              = CMD_READ;
        i_cmd_addr            = '0;
        i_cmd_mask            = '0;
        i_cmd_value           = '0;
        i_cfg_bus_number      = 8'h03;
        i_cfg_device_number   = 5'h02;
        i_cfg_function_number = 3'h1;
        i_cfg_command         = 16'h0406;
        i_cfg_status          = 16'h0010;
        for (idx = 0; idx < MAX_VECS; idx++)
            vectors[idx] = '0;          // Test id 0 ends the list
        $readmemh("pcie_cfg_testdata.txt", vectors);

        repeat (8) @(posedge clk_pcie);
        #5;
        rst = 1'b0;

        idx = 0;
        while (idx < MAX_VECS && vectors[idx][71:68] != 4'd0)
        begin
            vec  = vectors[idx];
            name = $sformatf("%s[%0d]", test_name(vec[71:68]), idx);
            case (vec[67:64])
                4'd0:
                begin
                    read_word(name, vec[63:48], data);
                    check_value(name, vec[15:0], data & vec[47:32]);
                    check_mirrored_ports(name, vec[63:48], vec[47:32], vec[15:0]);
                end
                4'd1: issue_cmd(CMD_WRITE, vec[63:48], vec[47:32], vec[31:16]);
                4'd2: poll_until(name, vec[63:48], vec[47:32], vec[15:0]);
                4'd3: capture_write_fields();
                4'd4:
                begin
                    case (vec[49:48])   // Captured field select
                        2'd0:    data = snap_di[15:0];
                        2'd1:    data = snap_di[31:16];
                        2'd2:    data = {4'd0, snap_rw1c, snap_rdonly, snap_dwaddr};
                        default: data = {12'd0, snap_byte_en};
                    endcase
                    check_value(name, vec[15:0], data & vec[47:32]);
                end
                4'd5:
                begin
                    @(negedge clk_pcie);
                    check_value(name, vec[15:0], {15'd0, o_cmd_ready} & vec[47:32]);
                    @(posedge clk_pcie);
                    #5;
                end
                4'd6: wait_ready();
                default:
                begin
                    errors = errors + 1;
                    $display("Unknown operation %0d on test data entry %0d", vec[67:64], idx);
                end
            endcase
            idx = idx + 1;
        end

        if (checks == 0)
        begin
            errors = errors + 1;
            $display("No checks ran, the test data file is missing or empty");
        end
        total_errors = errors + overlap_errors + u_pcie_cfg_top.u_pcie_cfg_assert.fail_count;
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, total_errors, timeouts);
        if (total_errors == 0 && timeouts == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: pcie_cfg_testdata.txt
// test op addr mask value expect; op 0 read, 1 write, 2 poll, 3 capture write fields,
// 4 check captured field (addr 0 di lo, 1 di hi, 2 dwaddr, 3 byte_en), 5 ready, 6 wait ready
1_0_0000_ffff_0000_2301
1_0_8000_ffff_0000_6745
1_0_0004_ffff_0000_001c
1_0_8004_ffff_0000_001c
1_0_001c_ffff_0000_0000
1_0_8020_ffff_0000_0000
1_0_8008_ffff_0000_cdef
1_0_800e_ffff_0000_0123
1_0_0008_ffff_0000_2203
1_0_000a_ffff_0000_0406
2_1_8008_00ff_a55a_0000
2_0_8008_ffff_0000_cd5a
2_1_000a_ffff_1234_0000
2_0_000a_ffff_0000_0406
3_1_8014_ffff_f006_0000
3_1_8002_0001_0001_0000
3_2_0014_0800_0000_0800
3_0_0014_ffff_0000_f806
3_0_0018_ffff_0000_0006
3_0_001a_ffff_0000_c0de
4_1_8010_ffff_5678_0000
4_1_8012_ffff_1234_0000
4_1_8014_ffff_300a_0000
4_1_8002_0002_0002_0000
4_3_0000_0000_0000_0000
4_4_0000_ffff_0000_5678
4_4_0001_ffff_0000_1234
4_4_0002_ffff_0000_000a
4_4_0003_ffff_0000_0003
4_2_0014_0bff_0000_080a
4_0_0014_ffff_0000_380a
6_1_8014_ffff_f015_0000
6_1_8002_0005_0005_0000
6_5_0000_0001_0000_0000
6_6_0000_0000_0000_0000
6_0_0014_0bff_0000_0815
6_5_0000_0001_0000_0001
6_1_8002_0004_0000_0000
5_1_8018_ffff_0014_0000
5_1_801a_ffff_0000_0000
5_1_8002_0018_0008_0000
5_3_0000_0000_0000_0000
5_4_0000_ffff_0000_0007
5_4_0001_ffff_0000_ff00
5_4_0002_ffff_0000_0001
5_4_0003_ffff_0000_0008

// File: pcie_cfg_top.sv
// Top level of the PCIe configuration register bank
`timescale 1ns/1ns

module pcie_cfg_top import pcie_cfg_pkg::*;
(
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_cmd_valid,
    input  cmd_op_e     i_cmd_op,
    input  cfg_addr_t   i_cmd_addr,
    input  logic [15:0] i_cmd_mask,
    input  logic [15:0] i_cmd_value,
    output logic        o_cmd_ready,
    output logic        o_rsp_valid,
    output cfg_addr_t   o_rsp_addr,
    output logic [15:0] o_rsp_data,
    input  logic [7:0]  i_cfg_bus_number,
    input  logic [4:0]  i_cfg_device_number,
    input  logic [2:0]  i_cfg_function_number,
    input  logic [15:0] i_cfg_command,
    input  logic [15:0] i_cfg_status,
    input  logic [31:0] i_cfg_mgmt_do,
    input  logic        i_cfg_mgmt_rd_wr_done,
    output logic        o_cfg_mgmt_rd_en,
    output logic        o_cfg_mgmt_wr_en,
    output logic [31:0] o_cfg_mgmt_di,
    output logic [9:0]  o_cfg_mgmt_dwaddr,
    output logic [3:0]  o_cfg_mgmt_byte_en,
    output logic        o_cfg_mgmt_wr_readonly,
    output logic        o_cfg_mgmt_wr_rw1c_as_rw,
    output logic [63:0] o_cfg_dsn,
    output logic [15:0] o_pcie_id
);

    logic        cmd_accept;
    logic        rd_pend;
    logic        wr_pend;
    logic        rd_taken;
    logic        wr_taken;
    logic        mgmt_busy;
    logic        clear_fire;
    logic        clear_status_en;
    logic        clear_command_en;
    logic [31:0] clear_limit;
    logic        res_valid;
    logic [9:0]  res_addr;
    logic [31:0] res_data;
    logic [3:0]  res_byte_en;

    pcie_cfg_regfile u_regfile (
        .clk_pcie                 (clk_pcie),
        .rst                      (rst),
        .i_cmd_valid              (i_cmd_valid),
        .i_cmd_op                 (i_cmd_op),
        .i_cmd_addr               (i_cmd_addr),
        .i_cmd_mask               (i_cmd_mask),
        .i_cmd_value              (i_cmd_value),
        .i_rd_taken               (rd_taken),
        .i_wr_taken               (wr_taken),
        .i_mgmt_busy              (mgmt_busy),
        .i_clear_fire             (clear_fire),
        .i_cfg_bus_number         (i_cfg_bus_number),
        .i_cfg_device_number      (i_cfg_device_number),
        .i_cfg_function_number    (i_cfg_function_number),
        .i_cfg_command            (i_cfg_command),
        .i_cfg_status             (i_cfg_status),
        .i_cfg_mgmt_do            (i_cfg_mgmt_do),
        .i_cfg_mgmt_rd_en         (o_cfg_mgmt_rd_en),
        .i_cfg_mgmt_wr_en         (o_cfg_mgmt_wr_en),
        .i_res_valid              (res_valid),
        .i_res_addr               (res_addr),
        .i_res_data               (res_data),
        .i_res_byte_en            (res_byte_en),
        .o_cmd_ready              (o_cmd_ready),
        .o_cmd_accept             (cmd_accept),
        .o_rsp_valid              (o_rsp_valid),
        .o_rsp_addr               (o_rsp_addr),
        .o_rsp_data               (o_rsp_data),
        .o_rd_pend                (rd_pend),
        .o_wr_pend                (wr_pend),
        .o_clear_status_en        (clear_status_en),
        .o_clear_command_en       (clear_command_en),
        .o_clear_limit            (clear_limit),
        .o_cfg_dsn                (o_cfg_dsn),
        .o_cfg_mgmt_di            (o_cfg_mgmt_di),
        .o_cfg_mgmt_dwaddr        (o_cfg_mgmt_dwaddr),
        .o_cfg_mgmt_byte_en       (o_cfg_mgmt_byte_en),
        .o_cfg_mgmt_wr_readonly   (o_cfg_mgmt_wr_readonly),
        .o_cfg_mgmt_wr_rw1c_as_rw (o_cfg_mgmt_wr_rw1c_as_rw),
        .o_pcie_id                (o_pcie_id)
    );

    pcie_cfg_mgmt_seq u_mgmt_seq (
        .clk_pcie              (clk_pcie),
        .rst                   (rst),
        .i_rd_pend             (rd_pend),
        .i_wr_pend             (wr_pend),
        .i_cfg_mgmt_rd_wr_done (i_cfg_mgmt_rd_wr_done),
        .i_cfg_mgmt_do         (i_cfg_mgmt_do),
        .i_cfg_mgmt_dwaddr     (o_cfg_mgmt_dwaddr),
        .i_cfg_mgmt_byte_en    (o_cfg_mgmt_byte_en),
        .o_rd_taken            (rd_taken),
        .o_wr_taken            (wr_taken),
        .o_busy                (mgmt_busy),
        .o_cfg_mgmt_rd_en      (o_cfg_mgmt_rd_en),
        .o_cfg_mgmt_wr_en      (o_cfg_mgmt_wr_en),
        .o_res_valid           (res_valid),
        .o_res_addr            (res_addr),
        .o_res_data            (res_data),
        .o_res_byte_en         (res_byte_en)
    );

    pcie_cfg_status_clear u_status_clear (
        .clk_pcie     (clk_pcie),
        .rst          (rst),
        .i_status_en  (clear_status_en),
        .i_command_en (clear_command_en),
        .i_limit      (clear_limit),
        .i_cmd_accept (cmd_accept),
        .i_rd_pend    (rd_pend),
        .i_wr_pend    (wr_pend),
        .i_mgmt_busy  (mgmt_busy),
        .o_fire       (clear_fire)
    );

endmodule
